// File: logic/obi_fetch_pkg.sv
/*
 * Shared widths, reset values and checksum functions for the OBI fetch path.
 * Imported by the adapter, the integrity FIFO and the testbench bus model.
 */
package obi_fetch_pkg;

  ////////////////////////////////
  // Bus widths
  ////////////////////////////////
  parameter int OBI_ADDR_W    = 32;
  parameter int OBI_DATA_W    = 32;
  parameter int OBI_ACHK_W    = 12;
  parameter int OBI_RCHK_W    = 5;
  parameter int OBI_PROT_W    = 3;
  parameter int OBI_MEMTYPE_W = 2;

  // Address phase values after reset
  // Machine mode instruction fetch, non-cacheable, non-bufferable
  parameter logic [OBI_ADDR_W-1:0]    OBI_ADDR_RST    = '0;
  parameter logic [OBI_PROT_W-1:0]    OBI_PROT_RST    = 3'b110;
  parameter logic [OBI_MEMTYPE_W-1:0] OBI_MEMTYPE_RST = 2'b00;

  ////////////////////////////////
  // Checksums
  ////////////////////////////////

  // Address phase checksum for a read-only instruction transfer
  function automatic logic [OBI_ACHK_W-1:0] obi_achk_calc(
    input logic [OBI_ADDR_W-1:0]    addr,
    input logic [OBI_PROT_W-1:0]    prot,
    input logic [OBI_MEMTYPE_W-1:0] memtype,
    input logic                     dbg
  );
    logic [OBI_ACHK_W-1:0] chk;
    // wdata bytes and atop are all zero, so their even parity is zero
    chk[11:7] = 5'b00000;
    chk[6]    = ~^dbg;
    // be = 4'b1111 and we = 0 on every fetch
    chk[5]    = ~^{4'b1111, 1'b0};
    chk[4]    = ~^{prot, memtype};
    chk[3]    = ^addr[31:24];
    chk[2]    = ^addr[23:16];
    chk[1]    = ^addr[15:8];
    // Fetches are word aligned on the bus
    chk[0]    = ^{addr[7:2], 2'b00};
    return chk;
  endfunction

  // Response checksum, one even-parity bit per rdata byte plus err
  function automatic logic [OBI_RCHK_W-1:0] obi_rchk_calc(
    input logic [OBI_DATA_W-1:0] rdata,
    input logic                  err
  );
    return {^err, ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage

// File: logic/obi_integrity_fifo.sv
/*
 * Tracks each outstanding OBI fetch transfer in order.
 * One entry per granted request holds the integrity attribute and any grant
 * parity error; the head entry is used to qualify the matching response.
 * Also flags responses that arrive with nothing outstanding.
 */
module obi_integrity_fifo import obi_fetch_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Grant parity error, live
  input  logic                  gntpar_err_i,

  // Attribute of the request on the address phase
  input  logic                  trans_integrity_i,
  input  logic                  integrity_check_en_i,

  // OBI handshake and response
  input  logic                  obi_req_i,
  input  logic                  obi_gnt_i,
  input  logic                  obi_rvalid_i,
  input  logic [OBI_DATA_W-1:0] obi_rdata_i,
  input  logic                  obi_err_i,
  input  logic [OBI_RCHK_W-1:0] obi_rchk_i,

  // Attributes aligned with the response
  output logic                  gntpar_err_resp_o,
  output logic                  integrity_resp_o,
  output logic                  rchk_err_resp_o,
  output logic                  protocol_err_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // Index of the last entry, pointers wrap here
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(MAX_OUTSTANDING - 1);

  // Entry storage
  logic             integrity_mem  [MAX_OUTSTANDING];
  logic             gntpar_err_mem [MAX_OUTSTANDING];

  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] cnt_q;

  // Sticky grant parity error while request waits for grant
  logic             gntpar_pend_q;

  logic             push;
  logic             pop;
  logic             empty;
  logic             head_integrity;
  logic             head_gntpar_err;

  ////////////////////////////////
  // Push and pop
  ////////////////////////////////

  // Transfer accepted on the address phase
  assign push  = obi_req_i && obi_gnt_i;
  assign empty = (cnt_q == '0);
  // Only a response with something outstanding retires an entry
  assign pop   = obi_rvalid_i && !empty;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == LAST_IDX) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == LAST_IDX) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Collect grant parity errors seen during a pending request
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      gntpar_pend_q <= 1'b0;
    end else if (push) begin
      gntpar_pend_q <= 1'b0;
    end else if (obi_req_i && gntpar_err_i) begin
      gntpar_pend_q <= 1'b1;
    end
  end

  // Entry write
  always_ff @(posedge clk) begin
    if (push) begin
      integrity_mem[wptr_q]  <= trans_integrity_i;
      // Includes an error in the grant cycle itself
      gntpar_err_mem[wptr_q] <= gntpar_err_i || gntpar_pend_q;
    end
  end

  ////////////////////////////////
  // Response side
  ////////////////////////////////

  // Head entry, masked when nothing is outstanding
  assign head_integrity  = !empty && integrity_mem[rptr_q];
  assign head_gntpar_err = !empty && gntpar_err_mem[rptr_q];

  assign integrity_resp_o  = head_integrity;
  assign gntpar_err_resp_o = head_gntpar_err;

  // Checksum only checked for transfers to integrity-protected memory
  assign rchk_err_resp_o = obi_rvalid_i && head_integrity && integrity_check_en_i &&
                           (obi_rchk_i != obi_rchk_calc(obi_rdata_i, obi_err_i));

  // Response with no transfer outstanding
  assign protocol_err_o = obi_rvalid_i && empty;

endmodule

// File: logic/instr_obi_adapter.sv
/*
 * Instruction fetch to OBI adapter.
 * Passes fetch requests onto the OBI address phase and holds them stable
 * while grant is withheld. Generates achk and reqpar, passes responses
 * straight back and collects bus integrity and protocol errors.
 */
module instr_obi_adapter import obi_fetch_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     integrity_check_en_i,

  // Fetch request
  input  logic                     trans_valid_i,
  output logic                     trans_ready_o,
  input  logic [OBI_ADDR_W-1:0]    trans_addr_i,
  input  logic [OBI_PROT_W-1:0]    trans_prot_i,
  input  logic [OBI_MEMTYPE_W-1:0] trans_memtype_i,
  input  logic                     trans_dbg_i,
  input  logic                     trans_integrity_i,

  // Fetch response, consumer always ready
  output logic                     resp_valid_o,
  output logic [OBI_DATA_W-1:0]    resp_rdata_o,
  output logic                     resp_err_o,
  output logic                     resp_integrity_o,
  output logic                     resp_integrity_err_o,

  // OBI address phase
  output logic                     obi_req_o,
  output logic                     obi_reqpar_o,
  output logic [OBI_ADDR_W-1:0]    obi_addr_o,
  output logic [OBI_PROT_W-1:0]    obi_prot_o,
  output logic [OBI_MEMTYPE_W-1:0] obi_memtype_o,
  output logic                     obi_dbg_o,
  output logic [OBI_ACHK_W-1:0]    obi_achk_o,
  input  logic                     obi_gnt_i,
  input  logic                     obi_gntpar_i,

  // OBI response phase
  input  logic                     obi_rvalid_i,
  input  logic                     obi_rvalidpar_i,
  input  logic [OBI_DATA_W-1:0]    obi_rdata_i,
  input  logic                     obi_err_i,
  input  logic [OBI_RCHK_W-1:0]    obi_rchk_i,

  // Error outputs
  output logic                     integrity_err_o,
  output logic                     protocol_err_o
);

  localparam logic ST_TRANSPARENT = 1'b0;
  localparam logic ST_REGISTERED  = 1'b1;

  logic                     state_q;
  logic                     state_d;
  logic                     capture;

  // Address phase held while waiting for grant
  logic [OBI_ADDR_W-1:0]    addr_q;
  logic [OBI_PROT_W-1:0]    prot_q;
  logic [OBI_MEMTYPE_W-1:0] memtype_q;
  logic                     dbg_q;
  logic                     integrity_q;
  logic                     obi_integrity;

  logic                     gntpar_err;
  logic                     rvalidpar_err;
  logic                     gntpar_err_resp;
  logic                     integrity_resp;
  logic                     rchk_err_resp;

  ////////////////////////////////
  // Address phase FSM
  ////////////////////////////////

  // Leave transparent on an ungranted request, return on grant
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_TRANSPARENT: if (obi_req_o && !obi_gnt_i) state_d = ST_REGISTERED;
      ST_REGISTERED:  if (obi_gnt_i) state_d = ST_TRANSPARENT;
      default:        state_d = ST_TRANSPARENT;
    endcase
  end

  assign capture = (state_q == ST_TRANSPARENT) && (state_d == ST_REGISTERED);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_TRANSPARENT;
      addr_q      <= OBI_ADDR_RST;
      prot_q      <= OBI_PROT_RST;
      memtype_q   <= OBI_MEMTYPE_RST;
      dbg_q       <= 1'b0;
      integrity_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        addr_q      <= trans_addr_i;
        prot_q      <= trans_prot_i;
        memtype_q   <= trans_memtype_i;
        dbg_q       <= trans_dbg_i;
        integrity_q <= trans_integrity_i;
      end
    end
  end

  // Live request in transparent state, held copy otherwise
  always_comb begin
    if (state_q == ST_TRANSPARENT) begin
      obi_req_o     = trans_valid_i;
      obi_addr_o    = trans_addr_i;
      obi_prot_o    = trans_prot_i;
      obi_memtype_o = trans_memtype_i;
      obi_dbg_o     = trans_dbg_i;
      obi_integrity = trans_integrity_i;
    end else begin
      // Request is never retracted
      obi_req_o     = 1'b1;
      obi_addr_o    = addr_q;
      obi_prot_o    = prot_q;
      obi_memtype_o = memtype_q;
      obi_dbg_o     = dbg_q;
      obi_integrity = integrity_q;
    end
  end

  assign obi_achk_o    = obi_achk_calc(obi_addr_o, obi_prot_o, obi_memtype_o, obi_dbg_o);
  assign obi_reqpar_o  = !obi_req_o;
  // No new request accepted while one is held
  assign trans_ready_o = (state_q == ST_TRANSPARENT);

  ////////////////////////////////
  // Response and integrity
  ////////////////////////////////

  // Parity lines must be the inverse of their strobes
  assign gntpar_err    = (obi_gnt_i == obi_gntpar_i);
  assign rvalidpar_err = (obi_rvalid_i == obi_rvalidpar_i);

  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_integrity_fifo (
    .clk                  (clk),
    .rst_n                (rst_n),
    .gntpar_err_i         (gntpar_err),
    .trans_integrity_i    (obi_integrity),
    .integrity_check_en_i (integrity_check_en_i),
    .obi_req_i            (obi_req_o),
    .obi_gnt_i            (obi_gnt_i),
    .obi_rvalid_i         (obi_rvalid_i),
    .obi_rdata_i          (obi_rdata_i),
    .obi_err_i            (obi_err_i),
    .obi_rchk_i           (obi_rchk_i),
    .gntpar_err_resp_o    (gntpar_err_resp),
    .integrity_resp_o     (integrity_resp),
    .rchk_err_resp_o      (rchk_err_resp),
    .protocol_err_o       (protocol_err_o)
  );

  // Response passes straight through
  assign resp_valid_o         = obi_rvalid_i;
  assign resp_rdata_o         = obi_rdata_i;
  assign resp_err_o           = obi_err_i;
  assign resp_integrity_o     = obi_rvalid_i && integrity_resp;
  assign resp_integrity_err_o = obi_rvalid_i && (rvalidpar_err || gntpar_err_resp ||
                                                 rchk_err_resp);

  // Immediate error, not tied to any response
  assign integrity_err_o = rchk_err_resp || rvalidpar_err || gntpar_err;

endmodule

// File: logic/instr_fetch_obi_top.sv
/*
 * Top level of the instruction fetch OBI adapter.
 * Exposes the fetch port and the OBI bus as loose ports and sets the
 * outstanding transfer depth for the adapter below.
 */
module instr_fetch_obi_top import obi_fetch_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     integrity_check_en_i,

  // Fetch side
  input  logic                     trans_valid_i,
  output logic                     trans_ready_o,
  input  logic [OBI_ADDR_W-1:0]    trans_addr_i,
  input  logic [OBI_PROT_W-1:0]    trans_prot_i,
  input  logic [OBI_MEMTYPE_W-1:0] trans_memtype_i,
  input  logic                     trans_dbg_i,
  input  logic                     trans_integrity_i,
  output logic                     resp_valid_o,
  output logic [OBI_DATA_W-1:0]    resp_rdata_o,
  output logic                     resp_err_o,
  output logic                     resp_integrity_o,
  output logic                     resp_integrity_err_o,

  // OBI bus
  output logic                     obi_req_o,
  output logic                     obi_reqpar_o,
  output logic [OBI_ADDR_W-1:0]    obi_addr_o,
  output logic [OBI_PROT_W-1:0]    obi_prot_o,
  output logic [OBI_MEMTYPE_W-1:0] obi_memtype_o,
  output logic                     obi_dbg_o,
  output logic [OBI_ACHK_W-1:0]    obi_achk_o,
  input  logic                     obi_gnt_i,
  input  logic                     obi_gntpar_i,
  input  logic                     obi_rvalid_i,
  input  logic                     obi_rvalidpar_i,
  input  logic [OBI_DATA_W-1:0]    obi_rdata_i,
  input  logic                     obi_err_i,
  input  logic [OBI_RCHK_W-1:0]    obi_rchk_i,

  // Errors
  output logic                     integrity_err_o,
  output logic                     protocol_err_o
);

  instr_obi_adapter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_adapter (
    .clk                  (clk),
    .rst_n                (rst_n),
    .integrity_check_en_i (integrity_check_en_i),
    .trans_valid_i        (trans_valid_i),
    .trans_ready_o        (trans_ready_o),
    .trans_addr_i         (trans_addr_i),
    .trans_prot_i         (trans_prot_i),
    .trans_memtype_i      (trans_memtype_i),
    .trans_dbg_i          (trans_dbg_i),
    .trans_integrity_i    (trans_integrity_i),
    .resp_valid_o         (resp_valid_o),
    .resp_rdata_o         (resp_rdata_o),
    .resp_err_o           (resp_err_o),
    .resp_integrity_o     (resp_integrity_o),
    .resp_integrity_err_o (resp_integrity_err_o),
    .obi_req_o            (obi_req_o),
    .obi_reqpar_o         (obi_reqpar_o),
    .obi_addr_o           (obi_addr_o),
    .obi_prot_o           (obi_prot_o),
    .obi_memtype_o        (obi_memtype_o),
    .obi_dbg_o            (obi_dbg_o),
    .obi_achk_o           (obi_achk_o),
    .obi_gnt_i            (obi_gnt_i),
    .obi_gntpar_i         (obi_gntpar_i),
    .obi_rvalid_i         (obi_rvalid_i),
    .obi_rvalidpar_i      (obi_rvalidpar_i),
    .obi_rdata_i          (obi_rdata_i),
    .obi_err_i            (obi_err_i),
    .obi_rchk_i           (obi_rchk_i),
    .integrity_err_o      (integrity_err_o),
    .protocol_err_o       (protocol_err_o)
  );

endmodule

// File: verif/tb_obi_slave.sv
/*
 * OBI memory model for the fetch adapter testbench.
 * Grants after a per-request delay, answers in order with the inverted
 * address as read data and err equal to address bit 2. Injects parity and
 * checksum errors on request and can send an rvalid with nothing outstanding.
 */
module tb_obi_slave import obi_fetch_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic [OBI_ADDR_W-1:0] addr_i,
  input  logic [7:0]            gnt_delay_i,
  input  logic [7:0]            rsp_delay_i,
  input  logic [2:0]            inject_i,
  input  logic                  spurious_i,
  output logic                  gnt_o,
  output logic                  gntpar_o,
  output logic                  rvalid_o,
  output logic                  rvalidpar_o,
  output logic [OBI_DATA_W-1:0] rdata_o,
  output logic                  err_o,
  output logic [OBI_RCHK_W-1:0] rchk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 8;

  // Parameters of a request held while grant is withheld
  logic        pend_q;
  logic [7:0]  gnt_delay_q;
  logic [7:0]  rsp_delay_q;
  logic [2:0]  inject_q;
  logic [7:0]  wait_q;
  logic [7:0]  cur_gnt_delay;
  logic [7:0]  cur_rsp_delay;
  logic [2:0]  cur_inject;

  // In-order queue of granted transfers
  logic [31:0] addr_mem [DEPTH];
  logic [31:0] due_mem  [DEPTH];
  logic [2:0]  inj_mem  [DEPTH];
  logic [2:0]  wr_q;
  logic [2:0]  rd_q;
  logic [3:0]  cnt_q;
  logic [31:0] cyc_q;

  logic        room;
  logic        push;
  logic        pop_rsp;
  logic [31:0] head_addr;

  assign cur_gnt_delay = pend_q ? gnt_delay_q : gnt_delay_i;
  assign cur_rsp_delay = pend_q ? rsp_delay_q : rsp_delay_i;
  assign cur_inject    = pend_q ? inject_q : inject_i;

  // Response on the bus still counts as outstanding for the adapter
  assign room     = (int'(cnt_q) + int'(rvalid_o)) < int'(MAX_OUTSTANDING);
  assign gnt_o    = req_i && (wait_q >= cur_gnt_delay) && room;
  // Bad gntpar only in the grant cycle
  assign gntpar_o = (gnt_o && cur_inject == 3'd1) ? 1'b1 : !gnt_o;
  assign push     = req_i && gnt_o;

  assign head_addr = addr_mem[rd_q];
  assign pop_rsp   = !spurious_i && (cnt_q != 4'd0) && (cyc_q >= due_mem[rd_q]);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pend_q      <= 1'b0;
      gnt_delay_q <= 8'd0;
      rsp_delay_q <= 8'd0;
      inject_q    <= 3'd0;
      wait_q      <= 8'd0;
      wr_q        <= 3'd0;
      rd_q        <= 3'd0;
      cnt_q       <= 4'd0;
      cyc_q       <= 32'd0;
      rvalid_o    <= 1'b0;
      rvalidpar_o <= 1'b1;
      rdata_o     <= '0;
      err_o       <= 1'b0;
      rchk_o      <= '0;
    end else begin
      cyc_q <= cyc_q + 32'd1;
      // Grant delay counter and parameter capture
      if (push) begin
        pend_q <= 1'b0;
        wait_q <= 8'd0;
        wr_q   <= wr_q + 3'd1;
      end else if (req_i) begin
        wait_q <= wait_q + 8'd1;
        if (!pend_q) begin
          pend_q      <= 1'b1;
          gnt_delay_q <= gnt_delay_i;
          rsp_delay_q <= rsp_delay_i;
          inject_q    <= inject_i;
        end
      end
      // Idle bus by default
      rvalid_o    <= 1'b0;
      rvalidpar_o <= 1'b1;
      if (spurious_i) begin
        rvalid_o    <= 1'b1;
        rvalidpar_o <= 1'b0;
        rdata_o     <= '0;
        err_o       <= 1'b0;
        rchk_o      <= obi_rchk_calc('0, 1'b0);
      end else if (pop_rsp) begin
        rvalid_o    <= 1'b1;
        rvalidpar_o <= (inj_mem[rd_q] == 3'd2);
        rdata_o     <= ~head_addr;
        err_o       <= head_addr[2];
        rchk_o      <= obi_rchk_calc(~head_addr, head_addr[2]) ^
                       ((inj_mem[rd_q] == 3'd3) ? 5'b00001 : 5'b00000);
        rd_q        <= rd_q + 3'd1;
      end
      case ({push, pop_rsp})
        2'b10:   cnt_q <= cnt_q + 4'd1;
        2'b01:   cnt_q <= cnt_q - 4'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry write
  always @(posedge clk) begin
    if (rst_n && push) begin
      addr_mem[wr_q] <= addr_i;
      due_mem[wr_q]  <= cyc_q + 32'(cur_rsp_delay);
      inj_mem[wr_q]  <= cur_inject;
    end
  end

endmodule

// File: verif/tb_instr_fetch_obi.sv
/*
 * Testbench for the instruction fetch OBI adapter.
 * Reads fetch patterns, drives the fetch port, lets the OBI model answer
 * and checks address phase, responses and error outputs every cycle.
 */
module tb_instr_fetch_obi;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_PAT    = 64;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
    logic        integ;
    logic [2:0]  inject;
    logic        err;
  } rec_t;

  logic        clk;
  logic        rst_n;
  logic        integrity_check_en_i;
  logic        trans_valid_i;
  logic        trans_ready_o;
  logic [31:0] trans_addr_i;
  logic [2:0]  trans_prot_i;
  logic [1:0]  trans_memtype_i;
  logic        trans_dbg_i;
  logic        trans_integrity_i;
  logic        resp_valid_o;
  logic [31:0] resp_rdata_o;
  logic        resp_err_o;
  logic        resp_integrity_o;
  logic        resp_integrity_err_o;
  logic        obi_req_o;
  logic        obi_reqpar_o;
  logic [31:0] obi_addr_o;
  logic [2:0]  obi_prot_o;
  logic [1:0]  obi_memtype_o;
  logic        obi_dbg_o;
  logic [11:0] obi_achk_o;
  logic        obi_gnt_i;
  logic        obi_gntpar_i;
  logic        obi_rvalid_i;
  logic        obi_rvalidpar_i;
  logic [31:0] obi_rdata_i;
  logic        obi_err_i;
  logic [4:0]  obi_rchk_i;
  logic        integrity_err_o;
  logic        protocol_err_o;

  // Per-request controls for the bus model
  logic [7:0]  gnt_delay;
  logic [7:0]  rsp_delay;
  logic [2:0]  cur_inject;
  logic        cur_exp_err;
  logic        spurious;

  // Pattern table
  logic [31:0] pat_addr [MAX_PAT];
  logic [2:0]  pat_prot [MAX_PAT];
  logic [1:0]  pat_mem  [MAX_PAT];
  logic        pat_dbg  [MAX_PAT];
  logic        pat_int  [MAX_PAT];
  logic [7:0]  pat_gdly [MAX_PAT];
  logic [7:0]  pat_rdly [MAX_PAT];
  logic [2:0]  pat_inj  [MAX_PAT];
  logic        pat_err  [MAX_PAT];
  int          n_pat;
  bit          loaded;

  // Scoreboard owned by the monitor
  rec_t        aphase_q[$];
  rec_t        resp_q[$];
  bit          hold_active;
  int          spurious_seen;
  int          spurious_exp;
  int          seed;

  instr_fetch_obi_top #(
    .MAX_OUTSTANDING (2)
  ) i_dut (.*);

  tb_obi_slave #(
    .MAX_OUTSTANDING (2)
  ) i_bus (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (obi_req_o),
    .addr_i      (obi_addr_o),
    .gnt_delay_i (gnt_delay),
    .rsp_delay_i (rsp_delay),
    .inject_i    (cur_inject),
    .spurious_i  (spurious),
    .gnt_o       (obi_gnt_i),
    .gntpar_o    (obi_gntpar_i),
    .rvalid_o    (obi_rvalid_i),
    .rvalidpar_o (obi_rvalidpar_i),
    .rdata_o     (obi_rdata_i),
    .err_o       (obi_err_i),
    .rchk_o      (obi_rchk_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR @ %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Address checksum rebuilt from the bus rules
  function automatic logic [11:0] expected_achk(input logic [31:0] addr,
                                                input logic [2:0] prot,
                                                input logic [1:0] memtype,
                                                input logic dbg);
    logic [11:0] chk;
    logic [31:0] a;
    a      = addr & 32'hffff_fffc;
    chk    = '0;
    chk[6] = !dbg;
    // be has four ones, we is zero, so inverted parity is one
    chk[5] = 1'b1;
    chk[4] = !(prot[0] ^ prot[1] ^ prot[2] ^ memtype[0] ^ memtype[1]);
    for (int b = 0; b < 4; b++) begin
      chk[b] = ^a[8*b +: 8];
    end
    return chk;
  endfunction

  ////////////////////////////////
  // Monitor
  ////////////////////////////////
  always @(posedge clk) begin : monitor
    rec_t rec;
    logic gnt_err;
    logic rsp_err;
    gnt_err = 1'b0;
    rsp_err = 1'b0;
    if (rst_n) begin
      if (trans_valid_i && trans_ready_o) begin
        aphase_q.push_back({trans_addr_i, trans_prot_i, trans_memtype_i, trans_dbg_i,
                            trans_integrity_i, cur_inject, cur_exp_err});
      end
      check_value(32'(obi_reqpar_o), 32'(!obi_req_o), "obi_reqpar_o");
      if (obi_req_o) begin
        check_value(32'(obi_achk_o),
                    32'(expected_achk(obi_addr_o, obi_prot_o, obi_memtype_o, obi_dbg_o)),
                    "obi_achk_o");
      end
      // Held address phase must match the captured request
      if (hold_active) begin
        rec = aphase_q[0];
        check_value(32'(obi_req_o), 32'd1, "obi_req_o held");
        check_value(32'(trans_ready_o), 32'd0, "trans_ready_o held");
        check_value(obi_addr_o, rec.addr, "obi_addr_o held");
        check_value(32'(obi_prot_o), 32'(rec.prot), "obi_prot_o held");
        check_value(32'(obi_memtype_o), 32'(rec.memtype), "obi_memtype_o held");
        check_value(32'(obi_dbg_o), 32'(rec.dbg), "obi_dbg_o held");
      end else begin
        check_value(32'(obi_req_o), 32'(trans_valid_i), "obi_req_o transparent");
        check_value(32'(trans_ready_o), 32'd1, "trans_ready_o transparent");
      end
      // Response side is checked before this cycle's grant joins the queue
      if (resp_valid_o) begin
        if (resp_q.size() == 0) begin
          check_value(32'(protocol_err_o), 32'd1, "protocol_err_o");
          check_value(32'(resp_integrity_o), 32'd0, "resp_integrity_o spurious");
          check_value(32'(resp_integrity_err_o), 32'd0, "resp_integrity_err_o spurious");
          spurious_seen++;
        end else begin
          rec     = resp_q.pop_front();
          rsp_err = (rec.inject == 3'd2) ||
                    ((rec.inject == 3'd3) && rec.integ && integrity_check_en_i);
          check_value(32'(protocol_err_o), 32'd0, "protocol_err_o");
          check_value(resp_rdata_o, ~rec.addr, "resp_rdata_o");
          check_value(32'(resp_err_o), 32'(rec.err), "resp_err_o");
          check_value(32'(resp_integrity_o), 32'(rec.integ), "resp_integrity_o");
          check_value(32'(resp_integrity_err_o), 32'(rsp_err || rec.inject == 3'd1),
                      "resp_integrity_err_o");
        end
      end else begin
        check_value(32'(protocol_err_o), 32'd0, "protocol_err_o idle");
      end
      if (obi_req_o && obi_gnt_i) begin
        if (aphase_q.size() == 0) begin
          $display("Bus granted a request that the fetch side never made");
          $display("Test failed");
          $fatal(1);
        end
        rec     = aphase_q.pop_front();
        gnt_err = (rec.inject == 3'd1);
        resp_q.push_back(rec);
      end
      hold_active = obi_req_o && !obi_gnt_i;
      check_value(32'(integrity_err_o), 32'(gnt_err || rsp_err), "integrity_err_o");
    end
  end

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  // Returns on a rising edge once nothing is in flight
  task automatic drain_outstanding();
    @(negedge clk);
    while (resp_q.size() != 0 || aphase_q.size() != 0) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic issue_fetch(input int i);
    trans_valid_i     <= 1'b1;
    trans_addr_i      <= pat_addr[i];
    trans_prot_i      <= pat_prot[i];
    trans_memtype_i   <= pat_mem[i];
    trans_dbg_i       <= pat_dbg[i];
    trans_integrity_i <= pat_int[i];
    gnt_delay         <= pat_gdly[i];
    rsp_delay         <= pat_rdly[i];
    cur_inject        <= pat_inj[i];
    cur_exp_err       <= pat_err[i];
    @(posedge clk);
    while (!trans_ready_o) @(posedge clk);
    trans_valid_i <= 1'b0;
  endtask

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [9];
    fd = $fopen("verif/fetch_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open pattern file verif/fetch_patterns.txt");
      $display("Test failed");
      $fatal(1);
    end
    n_pat = 0;
    while (!$feof(fd) && n_pat < MAX_PAT) begin
      if ($fgets(line, fd) == 0) break;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (line.len() > 0 && line.getc(0) != 8'h23 && cnt == 9) begin
        pat_addr[n_pat] = f[0];
        pat_prot[n_pat] = f[1][2:0];
        pat_mem[n_pat]  = f[2][1:0];
        pat_dbg[n_pat]  = f[3][0];
        pat_int[n_pat]  = f[4][0];
        pat_gdly[n_pat] = f[5][7:0];
        pat_rdly[n_pat] = f[6][7:0];
        pat_inj[n_pat]  = f[7][2:0];
        pat_err[n_pat]  = f[8][0];
        n_pat++;
      end
    end
    $fclose(fd);
  endtask

  initial begin : stimulus
    int gap;
    seed                 = 32'h5ddd;
    rst_n                <= 1'b0;
    integrity_check_en_i <= 1'b1;
    trans_valid_i        <= 1'b0;
    trans_addr_i         <= '0;
    trans_prot_i         <= '0;
    trans_memtype_i      <= '0;
    trans_dbg_i          <= 1'b0;
    trans_integrity_i    <= 1'b0;
    gnt_delay            <= '0;
    rsp_delay            <= '0;
    cur_inject           <= '0;
    cur_exp_err          <= 1'b0;
    spurious             <= 1'b0;
    hold_active          = 1'b0;
    load_patterns();
    if (n_pat < 4) begin
      $display("Pattern file holds too few fetches");
      $display("Test failed");
      $fatal(1);
    end
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < n_pat; i++) begin
      // Last four fetches run with checksum checking off
      if (i == n_pat - 4) begin
        drain_outstanding();
        integrity_check_en_i <= 1'b0;
      end
      gap = $random(seed) & 32'h3;
      repeat (gap) @(posedge clk);
      if (pat_inj[i] == 3'd4) begin
        drain_outstanding();
        spurious <= 1'b1;
        @(posedge clk);
        spurious <= 1'b0;
        spurious_exp++;
      end
      issue_fetch(i);
    end
    drain_outstanding();
    repeat (4) @(posedge clk);
    check_value(32'(spurious_seen), 32'(spurious_exp), "spurious response count");
    $display("Test passed");
    $finish;
  end

  // Watchdog scaled to the pattern count
  initial begin : watchdog
    wait (loaded);
    #(n_pat * 64 * CLK_PERIOD);
    $display("Simulation timed out before all fetches completed");
    $display("Test failed");
    $fatal(1);
  end

endmodule

// File: verif/fetch_patterns.txt
# addr prot memtype dbg integrity gnt_delay rsp_delay inject exp_err (all hex)
# inject: 0 none, 1 bad gntpar, 2 bad rvalidpar, 3 bad rchk, 4 spurious rvalid first
00001000 6 0 0 1 0 1 0 0
00001004 6 0 0 1 0 1 0 1
00001008 6 1 0 0 2 3 0 0
0000100c 6 1 1 1 3 2 0 1
80000010 7 2 0 1 0 6 0 0
80000014 7 2 0 0 0 6 0 1
80000018 6 3 1 1 1 5 0 0
8000001c 6 3 0 1 0 5 0 1
00005002 6 0 1 0 2 2 0 0
00002020 6 0 0 1 2 2 1 0
00002024 6 0 0 0 0 2 1 1
00002028 6 0 0 1 0 3 2 0
0000202c 6 0 1 0 1 1 2 1
00003030 6 0 0 1 0 2 3 0
00003034 6 0 0 0 0 2 3 1
00003038 6 2 0 1 4 1 4 0
0000303c 6 2 0 0 0 0 0 1
deadbee0 6 1 1 1 2 4 0 0
deadbee4 6 1 0 1 0 4 0 1
12345678 7 3 1 0 3 0 0 0
1234567c 7 3 0 1 0 0 4 1
00004040 6 0 0 1 0 2 3 0
00004044 6 0 0 1 1 3 3 1
00004048 6 0 0 1 0 1 0 0
0000404c 6 0 0 1 0 1 1 1

// File: sim.f
logic/obi_fetch_pkg.sv
logic/obi_integrity_fifo.sv
logic/instr_obi_adapter.sv
logic/instr_fetch_obi_top.sv
verif/tb_obi_slave.sv
verif/tb_instr_fetch_obi.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch adapter testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=tb_instr_fetch_obi
LOG=sim.log

verilator --binary --timing \
  --top-module "${TOP}" \
  -Mdir build/obj_dir \
  -f sim.f

# The run itself may exit non-zero on failure, the log decides
./build/obj_dir/V${TOP} > "${LOG}" 2>&1 || true
cat "${LOG}"

if grep -q "Test passed" "${LOG}"; then
  exit 0
else
  exit 1
fi
